// ==== dbg_top.f ====
logic/dbg_pkg.sv
logic/dmi_if.sv
logic/jtag_tap.sv
logic/sba_regs.sv
logic/sba_mem.sv
logic/dbg_top.sv
tests/tb_dbg_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the JTAG debug port testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_dbg_top -f dbg_top.f -o tb_dbg_top

./obj_dir/tb_dbg_top > sim.log
cat sim.log

if grep -q "^Done: no errors$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// ==== tests/tb_dbg_top.sv ====
// TDI/TMS change on rising TCK and TDO is sampled on falling TCK; only written words are checked
`timescale 1ns/1ps
`default_nettype none

module tb_dbg_top import dbg_pkg::*; ();

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 5;
  // About 400 scans of at most 50 TCK each, with 2.5x margin
  localparam int SCAN_ESTIMATE = 400;
  localparam int SCAN_CYCLES   = 50;
  localparam int TIMEOUT_NS    = SCAN_ESTIMATE * SCAN_CYCLES * CLK_PERIOD * 5 / 2;
  localparam word_t SBCS_WR_MASK = (32'd1 << SBCS_READONADDR_BIT) |
                                   (32'd1 << SBCS_AUTOINC_BIT) | (32'd1 << SBCS_READONDATA_BIT);

  logic jtag_tck;
  logic rst_n_i;
  logic tms_i;
  logic tdi_i;
  logic tdo_o;

  integer      seed = 22703;
  int          error_count;
  int          check_count;
  word_t       ref_sbcs;
  word_t       ref_addr;
  word_t       ref_data;
  word_t       ref_mem [MEM_WORDS];
  word_t       got_q [$];
  word_t       exp_q [$];
  string       tag_q [$];
  word_t       cmp_got;
  word_t       cmp_exp;
  string       cmp_tag;
  word_t       rnd;
  word_t       wdata;
  word_t       start_addr;
  logic [63:0] dr_out;
  ir_t         ir_out;
  logic        tdo_bit;
  mem_idx_t    idx;
  mem_idx_t    written [$];

  dbg_top dut (
    .jtag_tck (jtag_tck),
    .rst_n_i  (rst_n_i),
    .tms_i    (tms_i),
    .tdi_i    (tdi_i),
    .tdo_o    (tdo_o)
  );

  always #(CLK_PERIOD / 2) jtag_tck = ~jtag_tck;

  ////////////////////////////////////////////////////////////
  // Reference model of the system bus registers
  ////////////////////////////////////////////////////////////

  function automatic word_t ref_access(input dmi_addr_t addr, input word_t data,
                                       input dmi_op_e op);
    word_t result;
    result = '0;
    if (op == DMI_WRITE) begin
      case (addr)
        ADDR_SBCS: ref_sbcs = data & SBCS_WR_MASK;
        ADDR_SBADDRESS0: begin
          ref_addr = data;
          if (ref_sbcs[SBCS_READONADDR_BIT]) begin
            ref_data = ref_mem[ref_addr[9:2]];
            if (ref_sbcs[SBCS_AUTOINC_BIT]) ref_addr = ref_addr + 32'd4;
          end
        end
        ADDR_SBDATA0: begin
          ref_data = data;
          ref_mem[ref_addr[9:2]] = data;
          if (ref_sbcs[SBCS_AUTOINC_BIT]) ref_addr = ref_addr + 32'd4;
        end
        default: ;
      endcase
    end else if (op == DMI_READ) begin
      case (addr)
        ADDR_SBCS:       result = SBCS_RO_VALUE | ref_sbcs;
        ADDR_SBADDRESS0: result = ref_addr;
        ADDR_SBDATA0: begin
          result = ref_data;
          // Prefetch of the next word after the read
          if (ref_sbcs[SBCS_READONDATA_BIT]) begin
            ref_data = ref_mem[ref_addr[9:2]];
            if (ref_sbcs[SBCS_AUTOINC_BIT]) ref_addr = ref_addr + 32'd4;
          end
        end
        default: result = '0;
      endcase
    end
    return result;
  endfunction

  ////////////////////////////////////////////////////////////
  // JTAG driver tasks
  ////////////////////////////////////////////////////////////

  task automatic step_tap(input logic tms, input logic tdi, output logic tdo);
    @(posedge jtag_tck);
    tms_i <= tms;
    tdi_i <= tdi;
    @(negedge jtag_tck);
    tdo = tdo_o;
  endtask

  // LSB first, TMS high on the last bit
  task automatic shift_bits(input int len, input logic [63:0] din, output logic [63:0] dout);
    logic bit_out;
    dout = '0;
    for (int n = 0; n < len; n++) begin
      step_tap(n == len - 1, din[n], bit_out);
      dout[n] = bit_out;
    end
  endtask

  task automatic shift_ir(input ir_t code, output ir_t out);
    logic        unused;
    logic [63:0] dout;
    step_tap(1'b1, 1'b0, unused);
    step_tap(1'b1, 1'b0, unused);
    step_tap(1'b0, 1'b0, unused);
    step_tap(1'b0, 1'b0, unused);
    shift_bits(5, 64'(code), dout);
    step_tap(1'b1, 1'b0, unused);
    step_tap(1'b0, 1'b0, unused);
    out = dout[4:0];
  endtask

  task automatic shift_dr(input int len, input logic [63:0] din, output logic [63:0] dout);
    logic unused;
    step_tap(1'b1, 1'b0, unused);
    step_tap(1'b0, 1'b0, unused);
    step_tap(1'b0, 1'b0, unused);
    shift_bits(len, din, dout);
    step_tap(1'b1, 1'b0, unused);
    step_tap(1'b0, 1'b0, unused);
  endtask

  // Request scan, then a NOP scan to collect the read data
  task automatic dmi_access(input dmi_addr_t addr, input word_t data, input dmi_op_e op,
                            output word_t rdata);
    logic [63:0] frame;
    logic [63:0] dout;
    frame = '0;
    frame[DMI_DR_WIDTH-1:0] = {addr, data, op};
    shift_dr(DMI_DR_WIDTH, frame, dout);
    frame[DMI_DR_WIDTH-1:0] = {addr, 32'h0, DMI_NOP};
    shift_dr(DMI_DR_WIDTH, frame, dout);
    rdata = dout[33:2];
  endtask

  task automatic push_check(input string tag, input word_t got, input word_t exp);
    tag_q.push_back(tag);
    got_q.push_back(got);
    exp_q.push_back(exp);
  endtask

  task automatic bus_write(input dmi_addr_t addr, input word_t data);
    word_t unused;
    dmi_access(addr, data, DMI_WRITE, unused);
    void'(ref_access(addr, data, DMI_WRITE));
  endtask

  task automatic bus_read(input dmi_addr_t addr, input string tag);
    word_t got;
    word_t exp;
    dmi_access(addr, '0, DMI_READ, got);
    exp = ref_access(addr, '0, DMI_READ);
    push_check(tag, got, exp);
  endtask

  ////////////////////////////////////////////////////////////
  // Checker and watchdog
  ////////////////////////////////////////////////////////////

  always @(posedge jtag_tck) begin
    while (got_q.size() > 0) begin
      cmp_tag = tag_q.pop_front();
      cmp_got = got_q.pop_front();
      cmp_exp = exp_q.pop_front();
      check_count++;
      assert (cmp_got == cmp_exp) else begin
        $display("Mismatch at %0t: %s got %08h expected %08h", $time, cmp_tag, cmp_got,
                 cmp_exp);
        error_count++;
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: tests still running after %0d ns", TIMEOUT_NS);
    $display("Done: errors found");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    jtag_tck    = 1'b0;
    rst_n_i     = 1'b0;
    tms_i       = 1'b1;
    tdi_i       = 1'b0;
    error_count = 0;
    check_count = 0;
    ref_sbcs    = '0;
    ref_addr    = '0;
    ref_data    = '0;
    repeat (RESET_CYCLES) @(posedge jtag_tck);
    rst_n_i <= 1'b1;
    step_tap(1'b0, 1'b0, tdo_bit);

    // IDCODE straight after reset, then selected explicitly
    rnd = $random(seed);
    shift_dr(32, 64'(rnd), dr_out);
    push_check("idcode after reset", dr_out[31:0], IDCODE_VALUE);
    shift_ir(IR_IDCODE, ir_out);
    push_check("ir capture", 32'(ir_out[1:0]), 32'd1);
    shift_dr(32, 64'(rnd), dr_out);
    push_check("idcode selected", dr_out[31:0], IDCODE_VALUE);

    // One-bit delay through BYPASS and an unused code
    shift_ir(IR_BYPASS, ir_out);
    rnd = $random(seed);
    shift_dr(16, 64'(rnd[15:0]), dr_out);
    push_check("bypass", dr_out[31:0], {16'h0, rnd[14:0], 1'b0});
    shift_ir(5'd5, ir_out);
    rnd = $random(seed);
    shift_dr(16, 64'(rnd[15:0]), dr_out);
    push_check("unused code", dr_out[31:0], {16'h0, rnd[14:0], 1'b0});

    shift_ir(IR_DMI, ir_out);
    for (int i = 0; i < 8; i++) begin
      wdata = $random(seed);
      wdata[SBCS_READONADDR_BIT] = i[0];
      wdata[SBCS_AUTOINC_BIT]    = i[1];
      wdata[SBCS_READONDATA_BIT] = i[2];
      bus_write(ADDR_SBCS, wdata);
      bus_read(ADDR_SBCS, "sbcs readback");
    end

    // Burst write with autoincrement, then read back by prefetch
    rnd = $random(seed);
    start_addr = {rnd[31:10], 8'h40, 2'b00};
    bus_write(ADDR_SBCS, 32'd1 << SBCS_AUTOINC_BIT);
    bus_write(ADDR_SBADDRESS0, start_addr);
    for (int i = 0; i < 8; i++) begin
      bus_write(ADDR_SBDATA0, $random(seed));
      written.push_back(mem_idx_t'(start_addr[9:2] + i));
    end
    bus_write(ADDR_SBCS, SBCS_WR_MASK);
    bus_write(ADDR_SBADDRESS0, start_addr);
    for (int i = 0; i < 8; i++) begin
      bus_read(ADDR_SBDATA0, "burst readback");
    end
    bus_read(ADDR_SBADDRESS0, "address after burst");

    // Read on address, upper address bits must not matter
    bus_write(ADDR_SBCS, 32'd1 << SBCS_READONADDR_BIT);
    foreach (written[k]) begin
      for (int h = 0; h < 2; h++) begin
        rnd = $random(seed);
        bus_write(ADDR_SBADDRESS0, {(h != 0) ? rnd[31:10] : 22'h0, written[k], 2'b00});
        bus_read(ADDR_SBDATA0, "read on address");
      end
    end

    for (int i = 0; i < 40; i++) begin
      rnd   = $random(seed);
      wdata = $random(seed);
      if (rnd[31] || written.size() == 0) begin
        idx = rnd[7:0];
        written.push_back(idx);
        bus_write(ADDR_SBADDRESS0, {rnd[31:10], idx, 2'b00});
        bus_write(ADDR_SBDATA0, wdata);
      end else begin
        idx = written[rnd[15:8] % written.size()];
        bus_write(ADDR_SBADDRESS0, {wdata[31:10], idx, 2'b00});
        bus_read(ADDR_SBDATA0, "random read");
      end
    end

    repeat (2) @(posedge jtag_tck);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/dbg_top.sv ====
// All logic runs on jtag_tck; rst_n_i is synchronous and must be held for a few TCK cycles
`timescale 1ns/1ps
`default_nettype none

module dbg_top import dbg_pkg::*; (
  input  logic jtag_tck,
  input  logic rst_n_i,
  input  logic tms_i,
  input  logic tdi_i,
  output logic tdo_o
);

  logic     mem_we;
  logic     mem_re;
  mem_idx_t mem_idx;
  word_t    mem_wdata;
  word_t    mem_rdata;

  dmi_if dmi ();

  jtag_tap u_tap (
    .jtag_tck (jtag_tck),
    .rst_n_i  (rst_n_i),
    .tms_i    (tms_i),
    .tdi_i    (tdi_i),
    .tdo_o    (tdo_o),
    .dmi      (dmi.tap)
  );

  sba_regs u_regs (
    .jtag_tck    (jtag_tck),
    .rst_n_i     (rst_n_i),
    .dmi         (dmi.regs),
    .mem_we_o    (mem_we),
    .mem_re_o    (mem_re),
    .mem_idx_o   (mem_idx),
    .mem_wdata_o (mem_wdata),
    .mem_rdata_i (mem_rdata)
  );

  sba_mem u_mem (
    .jtag_tck    (jtag_tck),
    .rst_n_i     (rst_n_i),
    .mem_we_i    (mem_we),
    .mem_re_i    (mem_re),
    .mem_idx_i   (mem_idx),
    .mem_wdata_i (mem_wdata),
    .mem_rdata_o (mem_rdata)
  );

endmodule

`default_nettype wire

// ==== logic/sba_mem.sv ====
// Contents power up unknown and are not cleared; read data is valid the cycle after mem_re_i
`timescale 1ns/1ps
`default_nettype none

module sba_mem import dbg_pkg::*; (
  input  logic     jtag_tck,
  input  logic     rst_n_i,
  input  logic     mem_we_i,
  input  logic     mem_re_i,
  input  mem_idx_t mem_idx_i,
  input  word_t    mem_wdata_i,
  output word_t    mem_rdata_o
);

  word_t mem_q [MEM_WORDS];

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge jtag_tck) begin
    if (mem_we_i) begin
      mem_q[mem_idx_i] <= mem_wdata_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Registered read port
  ////////////////////////////////////////////////////////////

  // Output holds its value between reads
  always_ff @(posedge jtag_tck) begin
    if (!rst_n_i) begin
      mem_rdata_o <= '0;
    end else if (mem_re_i) begin
      mem_rdata_o <= mem_q[mem_idx_i];
    end
  end

endmodule

`default_nettype wire

// ==== logic/sba_regs.sv ====
// Memory answers in one cycle, so there is no busy or error state; accesses are 32-bit only
`timescale 1ns/1ps
`default_nettype none

module sba_regs import dbg_pkg::*; (
  input  logic     jtag_tck,
  input  logic     rst_n_i,
  dmi_if.regs      dmi,
  output logic     mem_we_o,
  output logic     mem_re_o,
  output mem_idx_t mem_idx_o,
  output word_t    mem_wdata_o,
  input  word_t    mem_rdata_i
);

  logic  readonaddr_q;
  logic  autoinc_q;
  logic  readondata_q;
  word_t sbaddress0_q;
  word_t sbdata0_q;
  logic  rd_pend_q;
  word_t sbcs_val;
  word_t read_val;
  logic  dmi_wr;
  logic  dmi_rd;

  assign dmi_wr = dmi.req && (dmi.op == DMI_WRITE);
  assign dmi_rd = dmi.req && (dmi.op == DMI_READ);

  // Memory always sees the live address and data registers
  assign mem_idx_o   = sbaddress0_q[MEM_IDX_LSB +: $bits(mem_idx_t)];
  assign mem_wdata_o = sbdata0_q;

  always_comb begin
    sbcs_val = SBCS_RO_VALUE;
    sbcs_val[SBCS_READONADDR_BIT] = readonaddr_q;
    sbcs_val[SBCS_AUTOINC_BIT]    = autoinc_q;
    sbcs_val[SBCS_READONDATA_BIT] = readondata_q;
  end

  always_comb begin
    case (dmi.addr)
      ADDR_SBCS:       read_val = sbcs_val;
      ADDR_SBADDRESS0: read_val = sbaddress0_q;
      ADDR_SBDATA0:    read_val = sbdata0_q;
      default:         read_val = '0;
    endcase
  end

  always_ff @(posedge jtag_tck) begin
    if (!rst_n_i) begin
      readonaddr_q <= 1'b0;
      autoinc_q    <= 1'b0;
      readondata_q <= 1'b0;
      sbaddress0_q <= '0;
      sbdata0_q    <= '0;
      rd_pend_q    <= 1'b0;
      mem_we_o     <= 1'b0;
      mem_re_o     <= 1'b0;
      dmi.rdata    <= '0;
    end else begin
      mem_we_o  <= 1'b0;
      mem_re_o  <= 1'b0;
      rd_pend_q <= mem_re_o;
      // Finish a pending access, read data lands one cycle after mem_re
      if (rd_pend_q) sbdata0_q <= mem_rdata_i;
      if ((rd_pend_q || mem_we_o) && autoinc_q) sbaddress0_q <= sbaddress0_q + 32'd4;
      if (dmi_wr) begin
        case (dmi.addr)
          ADDR_SBCS: begin
            readonaddr_q <= dmi.wdata[SBCS_READONADDR_BIT];
            autoinc_q    <= dmi.wdata[SBCS_AUTOINC_BIT];
            readondata_q <= dmi.wdata[SBCS_READONDATA_BIT];
          end
          ADDR_SBADDRESS0: begin
            sbaddress0_q <= dmi.wdata;
            mem_re_o     <= readonaddr_q;
          end
          ADDR_SBDATA0: begin
            sbdata0_q <= dmi.wdata;
            mem_we_o  <= 1'b1;
          end
          default: ;
        endcase
      end
      if (dmi_rd) begin
        dmi.rdata <= read_val;
        // Prefetch the next word after handing out the current one
        if (dmi.addr == ADDR_SBDATA0) mem_re_o <= readondata_q;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/jtag_tap.sv ====
// TDO changes on the rising TCK edge; rst_n_i replaces TRST; unknown IR codes select BYPASS
`timescale 1ns/1ps
`default_nettype none

module jtag_tap import dbg_pkg::*; (
  input  logic jtag_tck,
  input  logic rst_n_i,
  input  logic tms_i,
  input  logic tdi_i,
  output logic tdo_o,
  dmi_if.tap   dmi
);

  tap_state_e              state_q;
  tap_state_e              state_d;
  ir_t                     ir_sr_q;
  ir_t                     ir_q;
  word_t                   idcode_sr_q;
  logic                    bypass_sr_q;
  logic [DMI_DR_WIDTH-1:0] dmi_sr_q;
  dmi_op_e                 frame_op;
  logic                    sel_idcode;
  logic                    sel_dmi;
  logic                    sel_bypass;

  assign sel_idcode = (ir_q == IR_IDCODE);
  assign sel_dmi    = (ir_q == IR_DMI);
  assign sel_bypass = (ir_q == IR_BYPASS) || !(sel_idcode || sel_dmi);
  assign frame_op   = dmi_op_e'(dmi_sr_q[DMI_DATA_LSB-1:0]);

  ////////////////////////////////////////////////////////////
  // TAP state machine
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (state_q)
      TAP_RESET:      state_d = tms_i ? TAP_RESET     : TAP_IDLE;
      TAP_IDLE:       state_d = tms_i ? TAP_SELECT_DR : TAP_IDLE;
      TAP_SELECT_DR:  state_d = tms_i ? TAP_SELECT_IR : TAP_CAPTURE_DR;
      TAP_CAPTURE_DR: state_d = tms_i ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
      TAP_SHIFT_DR:   state_d = tms_i ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
      TAP_EXIT1_DR:   state_d = tms_i ? TAP_UPDATE_DR : TAP_PAUSE_DR;
      TAP_PAUSE_DR:   state_d = tms_i ? TAP_EXIT2_DR  : TAP_PAUSE_DR;
      TAP_EXIT2_DR:   state_d = tms_i ? TAP_UPDATE_DR : TAP_SHIFT_DR;
      TAP_UPDATE_DR:  state_d = tms_i ? TAP_SELECT_DR : TAP_IDLE;
      TAP_SELECT_IR:  state_d = tms_i ? TAP_RESET     : TAP_CAPTURE_IR;
      TAP_CAPTURE_IR: state_d = tms_i ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
      TAP_SHIFT_IR:   state_d = tms_i ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
      TAP_EXIT1_IR:   state_d = tms_i ? TAP_UPDATE_IR : TAP_PAUSE_IR;
      TAP_PAUSE_IR:   state_d = tms_i ? TAP_EXIT2_IR  : TAP_PAUSE_IR;
      TAP_EXIT2_IR:   state_d = tms_i ? TAP_UPDATE_IR : TAP_SHIFT_IR;
      TAP_UPDATE_IR:  state_d = tms_i ? TAP_SELECT_DR : TAP_IDLE;
      default:        state_d = TAP_RESET;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Instruction and data shift paths
  ////////////////////////////////////////////////////////////

  always_ff @(posedge jtag_tck) begin
    if (!rst_n_i) begin
      state_q     <= TAP_RESET;
      ir_sr_q     <= '0;
      ir_q        <= IR_IDCODE;
      idcode_sr_q <= '0;
      bypass_sr_q <= 1'b0;
      dmi_sr_q    <= '0;
      dmi.req     <= 1'b0;
      dmi.op      <= DMI_NOP;
      dmi.addr    <= '0;
      dmi.wdata   <= '0;
    end else begin
      state_q <= state_d;
      dmi.req <= 1'b0;
      case (state_q)
        TAP_RESET:      ir_q <= IR_IDCODE;
        TAP_CAPTURE_IR: ir_sr_q <= IR_CAPTURE;
        TAP_SHIFT_IR:   ir_sr_q <= {tdi_i, ir_sr_q[4:1]};
        TAP_UPDATE_IR:  ir_q <= ir_sr_q;
        TAP_CAPTURE_DR: begin
          if (sel_idcode) idcode_sr_q <= IDCODE_VALUE;
          if (sel_bypass) bypass_sr_q <= 1'b0;
          // Keep the last shifted address, report success
          if (sel_dmi) dmi_sr_q <= {dmi_sr_q[DMI_DR_WIDTH-1:DMI_ADDR_LSB], dmi.rdata, 2'b00};
        end
        TAP_SHIFT_DR: begin
          if (sel_idcode) idcode_sr_q <= {tdi_i, idcode_sr_q[31:1]};
          if (sel_bypass) bypass_sr_q <= tdi_i;
          if (sel_dmi) dmi_sr_q <= {tdi_i, dmi_sr_q[DMI_DR_WIDTH-1:1]};
        end
        TAP_UPDATE_DR: begin
          // NOP and the reserved op code issue nothing
          if (sel_dmi && (frame_op == DMI_READ || frame_op == DMI_WRITE)) begin
            dmi.req   <= 1'b1;
            dmi.op    <= frame_op;
            dmi.addr  <= dmi_sr_q[DMI_DR_WIDTH-1:DMI_ADDR_LSB];
            dmi.wdata <= dmi_sr_q[DMI_ADDR_LSB-1:DMI_DATA_LSB];
          end
        end
        default: ;
      endcase
    end
  end

  // LSB of the active path while shifting
  always_comb begin
    tdo_o = 1'b0;
    if (state_q == TAP_SHIFT_IR) begin
      tdo_o = ir_sr_q[0];
    end else if (state_q == TAP_SHIFT_DR) begin
      if (sel_idcode) tdo_o = idcode_sr_q[0];
      else if (sel_dmi) tdo_o = dmi_sr_q[0];
      else tdo_o = bypass_sr_q;
    end
  end

endmodule

`default_nettype wire

// ==== logic/dmi_if.sv ====
// No back-pressure: req is a one-cycle strobe and the register side must accept it at once
`timescale 1ns/1ps
`default_nettype none

interface dmi_if import dbg_pkg::*; ();

  logic      req;
  dmi_op_e   op;
  dmi_addr_t addr;
  word_t     wdata;
  // Holds the result of the last read until the next one
  word_t     rdata;

  modport tap (
    output req, op, addr, wdata,
    input  rdata
  );

  modport regs (
    input  req, op, addr, wdata,
    output rdata
  );

endinterface

`default_nettype wire

// ==== logic/dbg_pkg.sv ====
// Single 32-bit word access only; memory index uses address bits 9:2, higher bits are ignored
`default_nettype none

package dbg_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and plain vector types
  ////////////////////////////////////////////////////////////

  typedef logic [4:0]  ir_t;
  typedef logic [6:0]  dmi_addr_t;
  typedef logic [31:0] word_t;
  typedef logic [7:0]  mem_idx_t;

  localparam int unsigned MEM_WORDS   = 256;
  localparam int unsigned MEM_IDX_LSB = 2;

  ////////////////////////////////////////////////////////////
  // JTAG instructions and fixed values
  ////////////////////////////////////////////////////////////

  localparam ir_t IR_IDCODE = 5'd1;
  localparam ir_t IR_DMI    = 5'd17;
  localparam ir_t IR_BYPASS = 5'd31;

  // Value loaded into the IR shift path at Capture-IR
  localparam ir_t IR_CAPTURE = 5'b00001;

  // Bit 0 must stay set per 1149.1
  localparam word_t IDCODE_VALUE = 32'h1DBA_0001;

  // DMI frame layout, {addr, data, op}
  localparam int unsigned DMI_DR_WIDTH = 41;
  localparam int unsigned DMI_DATA_LSB = 2;
  localparam int unsigned DMI_ADDR_LSB = 34;

  typedef enum logic [1:0] {
    DMI_NOP   = 2'd0,
    DMI_READ  = 2'd1,
    DMI_WRITE = 2'd2
  } dmi_op_e;

  ////////////////////////////////////////////////////////////
  // System bus registers
  ////////////////////////////////////////////////////////////

  localparam dmi_addr_t ADDR_SBCS       = 7'h38;
  localparam dmi_addr_t ADDR_SBADDRESS0 = 7'h39;
  localparam dmi_addr_t ADDR_SBDATA0    = 7'h3C;

  // sbversion 1, sbaccess 2 (32 bit), sbasize 32
  localparam word_t SBCS_RO_VALUE = (32'd1 << 29) | (32'd2 << 17) | (32'd32 << 5);

  localparam int unsigned SBCS_READONADDR_BIT = 20;
  localparam int unsigned SBCS_AUTOINC_BIT    = 16;
  localparam int unsigned SBCS_READONDATA_BIT = 15;

  typedef enum logic [3:0] {
    TAP_RESET, TAP_IDLE,
    TAP_SELECT_DR, TAP_CAPTURE_DR, TAP_SHIFT_DR, TAP_EXIT1_DR,
    TAP_PAUSE_DR, TAP_EXIT2_DR, TAP_UPDATE_DR,
    TAP_SELECT_IR, TAP_CAPTURE_IR, TAP_SHIFT_IR, TAP_EXIT1_IR,
    TAP_PAUSE_IR, TAP_EXIT2_IR, TAP_UPDATE_IR
  } tap_state_e;

endpackage

`default_nettype wire
